// File: rtl/plic_gateway.sv
// ---------------------------------------------------------------------
// PLIC source gateway
// Synchronizes the raw sources, detects rising edges and turns them
// into pending set requests for sources that may interrupt
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module plic_gateway #(
    parameter int unsigned NUM_SOURCES = 31
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic [NUM_SOURCES-1:0] irq_sources_i,
    input  plic_pkg::src_mask_t in_service_i,
    input  plic_pkg::src_mask_t priority_nz_i,
    output plic_pkg::src_mask_t set_pending_o
);

    // First stage samples the pins, second holds the previous sample
    logic [NUM_SOURCES-1:0] sync_q;
    logic [NUM_SOURCES-1:0] prev_q;
    logic [NUM_SOURCES-1:0] rise;
    plic_pkg::src_mask_t    rise_mask;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sync_q <= '0;
            prev_q <= '0;
        end else begin
            sync_q <= irq_sources_i;
            prev_q <= sync_q;
        end
    end

    // Edge seen one cycle after sampling, pending sets on the next edge
    assign rise = sync_q & ~prev_q;

    // Pin k is source ID k+1
    always_comb begin
        rise_mask = '0;
        rise_mask[NUM_SOURCES:1] = rise;
    end

    // Drop edges from disabled (priority 0) or in-service sources
    assign set_pending_o = rise_mask & priority_nz_i & ~in_service_i;

    // ID 0 is "no interrupt" and must never become pending
    a_no_id_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !set_pending_o[0]);

endmodule

`default_nettype wire

// File: rtl/plic_pkg.sv
// ---------------------------------------------------------------------
// PLIC shared definitions
// Widths, register map offsets and the packed structs passed between
// the gateway, register block and per-target arbiters
// ---------------------------------------------------------------------
`default_nettype none

package plic_pkg;

    // Largest source count that fits one pending word (ID 0 is reserved)
    localparam int unsigned PLIC_MAX_SOURCES = 31;

    // Plain vector types
    typedef logic [4:0]  src_id_t;
    typedef logic [2:0]  prio_t;
    typedef logic [31:0] src_mask_t;
    typedef logic [31:0] word_t;

    // ---------------------------------------------------------------------
    // Register map, offsets from the PLIC base
    // ---------------------------------------------------------------------
    // Priority of source n at 4*n
    localparam word_t OFS_PRIORITY  = 32'h0000_0000;
    // Single pending word
    localparam word_t OFS_PENDING   = 32'h0000_1000;
    // Enable word of target t at 0x80*t
    localparam word_t OFS_ENABLE    = 32'h0000_2000;
    // Threshold of target t at 0x1000*t, claim/complete 4 bytes above
    localparam word_t OFS_THRESHOLD = 32'h0020_0000;

    // Bus request as seen by the register block
    typedef struct packed {
        logic  req;
        logic  we;
        word_t addr;
        word_t wdata;
    } plic_bus_req_t;

    // Configuration of one target
    typedef struct packed {
        src_mask_t enable;
        prio_t     threshold;
    } plic_target_cfg_t;

    // Claim/complete strobes for one target
    typedef struct packed {
        logic    claim_rd;
        logic    complete_wr;
        src_id_t complete_id;
    } plic_claim_cmd_t;

endpackage

`default_nettype wire

// File: rtl/plic_regs.sv
// ---------------------------------------------------------------------
// PLIC register block
// Decodes the memory-mapped port, holds priority, pending, enable and
// threshold state and issues claim/complete strobes per target
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module plic_regs #(
    parameter int unsigned     NUM_SOURCES = 31,
    parameter int unsigned     NUM_TARGETS = 2,
    parameter plic_pkg::word_t PLIC_BASE   = 32'h0C00_0000
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  plic_pkg::plic_bus_req_t    bus_req_i,
    output plic_pkg::word_t            rdata_o,
    output logic                       ready_o,
    input  plic_pkg::src_mask_t        set_pending_i,
    input  plic_pkg::src_mask_t        claim_clr_i,
    input  plic_pkg::src_id_t          best_id_i [NUM_TARGETS],
    output plic_pkg::src_mask_t        pending_o,
    output plic_pkg::prio_t            priority_o [1:NUM_SOURCES],
    output plic_pkg::src_mask_t        priority_nz_o,
    output plic_pkg::plic_target_cfg_t target_cfg_o [NUM_TARGETS],
    output plic_pkg::plic_claim_cmd_t  claim_cmd_o [NUM_TARGETS]
);

    // Bits 1..NUM_SOURCES
    localparam plic_pkg::src_mask_t SRC_VALID =
        ((plic_pkg::src_mask_t'(1) << NUM_SOURCES) - 1) << 1;

    plic_pkg::word_t            ofs;
    plic_pkg::word_t            en_rel;
    plic_pkg::word_t            thr_rel;
    plic_pkg::src_id_t          prio_idx;
    logic [4:0]                 en_tgt;
    logic [4:0]                 thr_tgt;
    logic                       hit_prio;
    logic                       hit_pend;
    logic                       hit_en;
    logic                       hit_thr;
    logic                       hit_claim;
    logic                       rd;
    logic                       wr;
    plic_pkg::src_mask_t        pending_q;
    plic_pkg::prio_t            prio_q [1:NUM_SOURCES];
    plic_pkg::plic_target_cfg_t cfg_q [NUM_TARGETS];

    // ---------------------------------------------------------------------
    // Address decode
    // ---------------------------------------------------------------------
    assign ofs      = bus_req_i.addr - PLIC_BASE;
    assign en_rel   = ofs - plic_pkg::OFS_ENABLE;
    assign thr_rel  = ofs - plic_pkg::OFS_THRESHOLD;
    assign prio_idx = ofs[6:2];
    assign en_tgt   = en_rel[11:7];
    assign thr_tgt  = thr_rel[16:12];

    // Priority slot 0 is reserved and left unmapped
    assign hit_prio = (ofs[31:7] == '0) && (ofs[1:0] == 2'b00) && (prio_idx != '0)
                      && (32'(prio_idx) <= NUM_SOURCES);
    assign hit_pend = (ofs == plic_pkg::OFS_PENDING);
    // Only word 0 of each enable bank
    assign hit_en   = (en_rel[31:12] == '0) && (en_rel[6:0] == '0)
                      && (32'(en_tgt) < NUM_TARGETS);
    // Wrapped subtraction leaves upper bits set below the window
    assign hit_thr  = (thr_rel[31:17] == '0) && (thr_rel[11:0] == 12'h000)
                      && (32'(thr_tgt) < NUM_TARGETS);
    assign hit_claim = (thr_rel[31:17] == '0) && (thr_rel[11:0] == 12'h004)
                      && (32'(thr_tgt) < NUM_TARGETS);

    assign ready_o = bus_req_i.req & (hit_prio | hit_pend | hit_en | hit_thr | hit_claim);
    assign rd      = ready_o & ~bus_req_i.we;
    assign wr      = ready_o & bus_req_i.we;

    // ---------------------------------------------------------------------
    // State
    // ---------------------------------------------------------------------
    // Set beats claim-clear in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= '0;
        end else begin
            pending_q <= ((pending_q & ~claim_clr_i) | set_pending_i) & SRC_VALID;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 1; s <= NUM_SOURCES; s++) begin
                prio_q[s] <= '0;
            end
            for (int t = 0; t < NUM_TARGETS; t++) begin
                cfg_q[t] <= '0;
            end
        end else if (wr) begin
            for (int s = 1; s <= NUM_SOURCES; s++) begin
                if (hit_prio && prio_idx == plic_pkg::src_id_t'(s)) begin
                    prio_q[s] <= bus_req_i.wdata[2:0];
                end
            end
            for (int t = 0; t < NUM_TARGETS; t++) begin
                if (hit_en && en_tgt == 5'(t)) begin
                    cfg_q[t].enable <= bus_req_i.wdata & SRC_VALID;
                end
                if (hit_thr && thr_tgt == 5'(t)) begin
                    cfg_q[t].threshold <= bus_req_i.wdata[2:0];
                end
            end
        end
    end

    // ---------------------------------------------------------------------
    // Read mux and claim strobes
    // ---------------------------------------------------------------------
    // Read data only for mapped reads, zero otherwise
    always_comb begin
        rdata_o = '0;
        if (rd && hit_pend) begin
            rdata_o = pending_q;
        end
        for (int s = 1; s <= NUM_SOURCES; s++) begin
            if (rd && hit_prio && prio_idx == plic_pkg::src_id_t'(s)) begin
                rdata_o = {29'd0, prio_q[s]};
            end
        end
        for (int t = 0; t < NUM_TARGETS; t++) begin
            if (rd && hit_en && en_tgt == 5'(t)) begin
                rdata_o = cfg_q[t].enable;
            end
            if (rd && hit_thr && thr_tgt == 5'(t)) begin
                rdata_o = {29'd0, cfg_q[t].threshold};
            end
            // Already zero from the target while a claim is held
            if (rd && hit_claim && thr_tgt == 5'(t)) begin
                rdata_o = {27'd0, best_id_i[t]};
            end
        end
    end

    // Completion IDs beyond 5 bits can never match a claim
    always_comb begin
        for (int t = 0; t < NUM_TARGETS; t++) begin
            claim_cmd_o[t].claim_rd    = rd && hit_claim && thr_tgt == 5'(t);
            claim_cmd_o[t].complete_wr = wr && hit_claim && thr_tgt == 5'(t)
                                         && bus_req_i.wdata[31:5] == '0;
            claim_cmd_o[t].complete_id = bus_req_i.wdata[4:0];
        end
    end

    always_comb begin
        priority_nz_o = '0;
        for (int s = 1; s <= NUM_SOURCES; s++) begin
            priority_nz_o[s] = (prio_q[s] != '0);
        end
    end

    assign pending_o    = pending_q;
    assign priority_o   = prio_q;
    assign target_cfg_o = cfg_q;

    a_ready_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ready_o |-> bus_req_i.req);

endmodule

`default_nettype wire

// File: rtl/plic_target.sv
// ---------------------------------------------------------------------
// PLIC per-target arbiter
// Picks the best eligible source, holds the claim and handles
// completion for one target
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module plic_target #(
    parameter int unsigned NUM_SOURCES = 31
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  plic_pkg::src_mask_t        pending_i,
    input  plic_pkg::prio_t            priority_i [1:NUM_SOURCES],
    input  plic_pkg::plic_target_cfg_t cfg_i,
    input  plic_pkg::plic_claim_cmd_t  cmd_i,
    output plic_pkg::src_id_t          best_id_o,
    output plic_pkg::src_mask_t        claim_clr_o,
    output plic_pkg::src_mask_t        in_service_o,
    output logic                       irq_o
);

    plic_pkg::src_id_t scan_id;
    plic_pkg::prio_t   scan_prio;
    plic_pkg::src_id_t claim_q;

    // ---------------------------------------------------------------------
    // Priority scan
    // ---------------------------------------------------------------------
    // Strict compare keeps the lowest ID on ties
    always_comb begin
        scan_id   = '0;
        scan_prio = '0;
        for (int s = 1; s <= NUM_SOURCES; s++) begin
            if (pending_i[s] && cfg_i.enable[s] && priority_i[s] > cfg_i.threshold
                && priority_i[s] > scan_prio) begin
                scan_id   = plic_pkg::src_id_t'(s);
                scan_prio = priority_i[s];
            end
        end
    end

    // No new interrupt is offered while one is in service
    assign best_id_o = (claim_q != '0) ? '0 : scan_id;
    assign irq_o     = (best_id_o != '0);

    // ---------------------------------------------------------------------
    // Claim register
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            claim_q <= '0;
        end else if (cmd_i.claim_rd && best_id_o != '0) begin
            claim_q <= best_id_o;
        end else if (cmd_i.complete_wr && cmd_i.complete_id == claim_q) begin
            // Mismatched IDs leave the claim untouched
            claim_q <= '0;
        end
    end

    // Pending clear pulse for the source being claimed
    assign claim_clr_o = (cmd_i.claim_rd && best_id_o != '0)
                         ? (plic_pkg::src_mask_t'(1) << best_id_o) : '0;

    // Held claim as a mask, ID 0 maps to nothing
    assign in_service_o = (plic_pkg::src_mask_t'(1) << claim_q)
                          & ~plic_pkg::src_mask_t'(1);

    a_claim_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
        32'(claim_q) <= NUM_SOURCES);

endmodule

`default_nettype wire

// File: rtl/plic_top.sv
// ---------------------------------------------------------------------
// PLIC top level
// Gateway, register block and one arbiter per target behind a
// single-cycle memory-mapped port
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module plic_top #(
    parameter int unsigned     NUM_SOURCES = 31,
    parameter int unsigned     NUM_TARGETS = 2,
    parameter plic_pkg::word_t PLIC_BASE   = 32'h0C00_0000
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic [NUM_SOURCES-1:0] irq_sources_i,
    input  logic                   mem_req_i,
    input  logic                   mem_we_i,
    input  plic_pkg::word_t        mem_addr_i,
    input  plic_pkg::word_t        mem_wdata_i,
    output plic_pkg::word_t        mem_rdata_o,
    output logic                   mem_ready_o,
    output logic [NUM_TARGETS-1:0] irq_o
);

    // One pending word holds every source
    if (NUM_SOURCES > plic_pkg::PLIC_MAX_SOURCES) begin : g_bad_cfg
        $error("NUM_SOURCES exceeds PLIC_MAX_SOURCES");
    end

    plic_pkg::plic_bus_req_t    bus_req;
    plic_pkg::src_mask_t        set_pending;
    plic_pkg::src_mask_t        pending;
    plic_pkg::src_mask_t        priority_nz;
    plic_pkg::prio_t            prio [1:NUM_SOURCES];
    plic_pkg::plic_target_cfg_t target_cfg [NUM_TARGETS];
    plic_pkg::plic_claim_cmd_t  claim_cmd [NUM_TARGETS];
    plic_pkg::src_id_t          best_id [NUM_TARGETS];
    plic_pkg::src_mask_t        claim_clr_t [NUM_TARGETS];
    plic_pkg::src_mask_t        in_service_t [NUM_TARGETS];
    plic_pkg::src_mask_t        claim_clr;
    plic_pkg::src_mask_t        in_service;

    assign bus_req = '{req: mem_req_i, we: mem_we_i, addr: mem_addr_i, wdata: mem_wdata_i};

    // Merge per-target masks
    always_comb begin
        claim_clr  = '0;
        in_service = '0;
        for (int t = 0; t < NUM_TARGETS; t++) begin
            claim_clr  = claim_clr | claim_clr_t[t];
            in_service = in_service | in_service_t[t];
        end
    end

    plic_gateway #(.NUM_SOURCES(NUM_SOURCES)) u_gateway (
        .clk_i, .rst_ni, .irq_sources_i,
        .in_service_i (in_service),
        .priority_nz_i(priority_nz),
        .set_pending_o(set_pending)
    );

    plic_regs #(
        .NUM_SOURCES(NUM_SOURCES), .NUM_TARGETS(NUM_TARGETS), .PLIC_BASE(PLIC_BASE)
    ) u_regs (
        .clk_i, .rst_ni,
        .bus_req_i    (bus_req),
        .rdata_o      (mem_rdata_o),
        .ready_o      (mem_ready_o),
        .set_pending_i(set_pending),
        .claim_clr_i  (claim_clr),
        .best_id_i    (best_id),
        .pending_o    (pending),
        .priority_o   (prio),
        .priority_nz_o(priority_nz),
        .target_cfg_o (target_cfg),
        .claim_cmd_o  (claim_cmd)
    );

    for (genvar t = 0; t < NUM_TARGETS; t++) begin : g_target
        plic_target #(.NUM_SOURCES(NUM_SOURCES)) u_target (
            .clk_i, .rst_ni,
            .pending_i   (pending),
            .priority_i  (prio),
            .cfg_i       (target_cfg[t]),
            .cmd_i       (claim_cmd[t]),
            .best_id_o   (best_id[t]),
            .claim_clr_o (claim_clr_t[t]),
            .in_service_o(in_service_t[t]),
            .irq_o       (irq_o[t])
        );
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PLIC testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf build
verilator --binary --timing --assert \
    -f sources.f \
    --top-module plic_tb \
    -Mdir build -o plic_sim

./build/plic_sim | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// File: sources.f
rtl/plic_pkg.sv
rtl/plic_gateway.sv
rtl/plic_regs.sv
rtl/plic_target.sv
rtl/plic_top.sv
verification/plic_checker.sv
verification/plic_tb.sv

// File: verification/plic_checker.sv
// ---------------------------------------------------------------------
// PLIC reference model and checker
// Cycle model of gateway, register map and claim logic that compares
// ready, read data and interrupt lines with the DUT every cycle
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module plic_checker #(
    parameter int unsigned     NUM_SOURCES = 31,
    parameter int unsigned     NUM_TARGETS = 2,
    parameter plic_pkg::word_t PLIC_BASE   = 32'h0C00_0000
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic [NUM_SOURCES-1:0] irq_sources_i,
    input  logic                   mem_req_i,
    input  logic                   mem_we_i,
    input  plic_pkg::word_t        mem_addr_i,
    input  plic_pkg::word_t        mem_wdata_i,
    input  plic_pkg::word_t        mem_rdata_i,
    input  logic                   mem_ready_i,
    input  logic [NUM_TARGETS-1:0] irq_i,
    output int unsigned            errors_o
);

    // Register classes of the decoded address
    localparam int C_NONE  = 0;
    localparam int C_PRIO  = 1;
    localparam int C_PEND  = 2;
    localparam int C_EN    = 3;
    localparam int C_THR   = 4;
    localparam int C_CLAIM = 5;

    // Source IDs 1..NUM_SOURCES
    localparam plic_pkg::src_mask_t VALID = ((32'd1 << NUM_SOURCES) - 32'd1) << 1;

    // Model state
    plic_pkg::src_mask_t m_pend;
    plic_pkg::src_mask_t m_en [NUM_TARGETS];
    plic_pkg::prio_t     m_thr [NUM_TARGETS];
    plic_pkg::src_id_t   m_claim [NUM_TARGETS];
    plic_pkg::prio_t     m_prio [32];
    logic [NUM_SOURCES-1:0] m_sync;
    logic [NUM_SOURCES-1:0] m_prev;

    // Per-cycle scratch
    plic_pkg::src_id_t   best [NUM_TARGETS];
    plic_pkg::word_t     ofs;
    plic_pkg::word_t     rel;
    plic_pkg::word_t     exp_rdata;
    plic_pkg::src_mask_t set_mask;
    plic_pkg::src_mask_t clr_mask;
    plic_pkg::src_mask_t in_svc;
    logic                exp_ready;
    int                  cls;
    int unsigned         idx;
    int unsigned         err_count = 0;

    assign errors_o = err_count;

    // Highest priority wins, scanning down so ties settle on the lowest ID
    function automatic plic_pkg::src_id_t best_for(input int t);
        plic_pkg::src_id_t id;
        plic_pkg::prio_t   p;
        id = '0;
        p  = '0;
        if (m_claim[t] != '0) begin
            return '0;
        end
        for (int s = NUM_SOURCES; s >= 1; s--) begin
            if (m_pend[s] && m_en[t][s] && m_prio[s] > m_thr[t] && m_prio[s] >= p) begin
                id = plic_pkg::src_id_t'(s);
                p  = m_prio[s];
            end
        end
        return id;
    endfunction

    task automatic report(input string sig, input plic_pkg::word_t exp, input plic_pkg::word_t act);
        $display("Error at %0d ns: %s expected %h, got %h", $time, sig, exp, act);
        err_count++;
    endtask

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            m_pend = '0;
            m_sync = '0;
            m_prev = '0;
            for (int s = 0; s < 32; s++) begin
                m_prio[s] = '0;
            end
            for (int t = 0; t < NUM_TARGETS; t++) begin
                m_en[t]    = '0;
                m_thr[t]   = '0;
                m_claim[t] = '0;
            end
        end else begin
            // ---------------------------------------------------------------
            // Decode the request against the register map
            // ---------------------------------------------------------------
            ofs = mem_addr_i - PLIC_BASE;
            cls = C_NONE;
            idx = 0;
            if (ofs[1:0] == 2'b00 && ofs >= 32'd4 && ofs <= 4 * NUM_SOURCES) begin
                cls = C_PRIO;
                idx = ofs >> 2;
            end else if (ofs == plic_pkg::OFS_PENDING) begin
                cls = C_PEND;
            end else if (ofs >= plic_pkg::OFS_ENABLE
                         && ofs < plic_pkg::OFS_ENABLE + 32'h80 * NUM_TARGETS
                         && ofs[6:0] == 7'd0) begin
                cls = C_EN;
                idx = (ofs - plic_pkg::OFS_ENABLE) >> 7;
            end else if (ofs >= plic_pkg::OFS_THRESHOLD
                         && ofs < plic_pkg::OFS_THRESHOLD + 32'h1000 * NUM_TARGETS) begin
                rel = ofs - plic_pkg::OFS_THRESHOLD;
                idx = rel >> 12;
                if (rel[11:0] == 12'h000) begin
                    cls = C_THR;
                end else if (rel[11:0] == 12'h004) begin
                    cls = C_CLAIM;
                end
            end

            for (int t = 0; t < NUM_TARGETS; t++) begin
                best[t] = best_for(t);
            end

            // Expected combinational outputs
            exp_ready = mem_req_i && cls != C_NONE;
            exp_rdata = '0;
            if (exp_ready && !mem_we_i) begin
                case (cls)
                    C_PRIO:  exp_rdata = {29'd0, m_prio[idx]};
                    C_PEND:  exp_rdata = m_pend;
                    C_EN:    exp_rdata = m_en[idx];
                    C_THR:   exp_rdata = {29'd0, m_thr[idx]};
                    C_CLAIM: exp_rdata = {27'd0, best[idx]};
                    default: exp_rdata = '0;
                endcase
            end

            if (mem_ready_i !== exp_ready) begin
                report("mem_ready_o", {31'd0, exp_ready}, {31'd0, mem_ready_i});
            end
            if (mem_rdata_i !== exp_rdata) begin
                report("mem_rdata_o", exp_rdata, mem_rdata_i);
            end
            for (int t = 0; t < NUM_TARGETS; t++) begin
                if (irq_i[t] !== (best[t] != '0)) begin
                    report($sformatf("irq_o[%0d]", t), {31'd0, best[t] != '0},
                           {31'd0, irq_i[t]});
                end
            end

            // ---------------------------------------------------------------
            // Next state
            // ---------------------------------------------------------------
            in_svc = '0;
            for (int t = 0; t < NUM_TARGETS; t++) begin
                if (m_claim[t] != '0) begin
                    in_svc[m_claim[t]] = 1'b1;
                end
            end

            // Edge found between the two sampled stages, gated by priority
            set_mask = '0;
            for (int s = 1; s <= NUM_SOURCES; s++) begin
                if (m_sync[s-1] && !m_prev[s-1] && m_prio[s] != '0 && !in_svc[s]) begin
                    set_mask[s] = 1'b1;
                end
            end

            clr_mask = '0;
            for (int t = 0; t < NUM_TARGETS; t++) begin
                if (exp_ready && cls == C_CLAIM && idx == t) begin
                    if (!mem_we_i && best[t] != '0) begin
                        clr_mask[best[t]] = 1'b1;
                        m_claim[t] = best[t];
                    end else if (mem_we_i && mem_wdata_i == {27'd0, m_claim[t]}) begin
                        m_claim[t] = '0;
                    end
                end
            end

            // A new edge outranks a claim in the same cycle
            m_pend = (m_pend & ~clr_mask) | set_mask;

            if (exp_ready && mem_we_i) begin
                case (cls)
                    C_PRIO:  m_prio[idx] = mem_wdata_i[2:0];
                    C_EN:    m_en[idx]   = mem_wdata_i & VALID;
                    C_THR:   m_thr[idx]  = mem_wdata_i[2:0];
                    default: ;
                endcase
            end

            m_prev = m_sync;
            m_sync = irq_sources_i;
        end
    end

endmodule

`default_nettype wire

// File: verification/plic_tb.sv
// ---------------------------------------------------------------------
// PLIC testbench
// Directed register, claim and threshold sequences followed by a
// seeded random mix of source toggles and bus accesses
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module plic_tb;

    localparam int unsigned     NUM_SOURCES  = 31;
    localparam int unsigned     NUM_TARGETS  = 2;
    localparam plic_pkg::word_t PLIC_BASE    = 32'h0C00_0000;
    localparam int unsigned     RESET_CYCLES = 16;
    localparam int unsigned     DIRECTED_CYC = 2000;
    localparam int unsigned     RANDOM_CYC   = 5000;
    // Run length in ns plus some slack
    localparam int unsigned     WATCHDOG_NS  = (RESET_CYCLES + DIRECTED_CYC + RANDOM_CYC) * 10
                                               + 2000;

    logic                   clk_i = 1'b0;
    logic                   rst_ni;
    logic [NUM_SOURCES-1:0] irq_sources_i;
    logic                   mem_req_i;
    logic                   mem_we_i;
    plic_pkg::word_t        mem_addr_i;
    plic_pkg::word_t        mem_wdata_i;
    plic_pkg::word_t        mem_rdata_o;
    logic                   mem_ready_o;
    logic [NUM_TARGETS-1:0] irq_o;
    int unsigned            model_errors;
    int unsigned            tb_errors = 0;

    always #5 clk_i = ~clk_i;

    plic_top #(
        .NUM_SOURCES(NUM_SOURCES), .NUM_TARGETS(NUM_TARGETS), .PLIC_BASE(PLIC_BASE)
    ) UUT (
        .clk_i, .rst_ni, .irq_sources_i, .mem_req_i, .mem_we_i, .mem_addr_i,
        .mem_wdata_i, .mem_rdata_o, .mem_ready_o, .irq_o
    );

    plic_checker #(
        .NUM_SOURCES(NUM_SOURCES), .NUM_TARGETS(NUM_TARGETS), .PLIC_BASE(PLIC_BASE)
    ) u_checker (
        .clk_i, .rst_ni, .irq_sources_i, .mem_req_i, .mem_we_i, .mem_addr_i,
        .mem_wdata_i,
        .mem_rdata_i(mem_rdata_o),
        .mem_ready_i(mem_ready_o),
        .irq_i      (irq_o),
        .errors_o   (model_errors)
    );

    // Register offsets
    function automatic plic_pkg::word_t prio_ofs(input int s);
        return plic_pkg::OFS_PRIORITY + 32'(4 * s);
    endfunction

    function automatic plic_pkg::word_t enable_ofs(input int t);
        return plic_pkg::OFS_ENABLE + 32'(32'h80 * t);
    endfunction

    function automatic plic_pkg::word_t thr_ofs(input int t);
        return plic_pkg::OFS_THRESHOLD + 32'(32'h1000 * t);
    endfunction

    // Mostly mapped offsets, with unmapped slots and stray addresses mixed in
    function automatic plic_pkg::word_t random_ofs();
        int unsigned sel;
        sel = $urandom_range(0, 9);
        case (sel)
            0, 1:    return prio_ofs(int'($urandom_range(0, 32)));
            2:       return plic_pkg::OFS_PENDING;
            3:       return enable_ofs(int'($urandom_range(0, NUM_TARGETS)));
            4:       return thr_ofs(int'($urandom_range(0, NUM_TARGETS)));
            5, 6, 7: return thr_ofs(int'($urandom_range(0, NUM_TARGETS - 1))) + 32'd4;
            8:       return $urandom;
            default: return 32'h0000_1004;
        endcase
    endfunction

    // One request cycle, then the port goes idle
    task automatic bus_cycle(input logic we, input plic_pkg::word_t ofs,
                             input plic_pkg::word_t data);
        @(negedge clk_i);
        mem_req_i   = 1'b1;
        mem_we_i    = we;
        mem_addr_i  = PLIC_BASE + ofs;
        mem_wdata_i = data;
        @(negedge clk_i);
        mem_req_i   = 1'b0;
        mem_we_i    = 1'b0;
    endtask

    // Pin id-1 carries source ID id
    task automatic pulse_source(input int id);
        @(negedge clk_i);
        irq_sources_i[id-1] = 1'b1;
        repeat (3) @(negedge clk_i);
        irq_sources_i[id-1] = 1'b0;
        repeat (3) @(negedge clk_i);
    endtask

    task automatic wait_irq(input int t, input logic level);
        int unsigned n;
        n = 0;
        while (irq_o[t] !== level && n < 10) begin
            @(negedge clk_i);
            n++;
        end
        if (irq_o[t] !== level) begin
            $display("Timeout at %0d ns: irq_o[%0d] never reached %0b", $time, t, level);
            tb_errors++;
        end
    endtask

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0d ns, the run did not finish", $time);
        $display("Checks failed");
        $finish;
    end

    initial begin
        plic_pkg::word_t r;
        int unsigned     pin;
        void'($urandom(97));
        rst_ni        = 1'b0;
        irq_sources_i = '0;
        mem_req_i     = 1'b0;
        mem_we_i      = 1'b0;
        mem_addr_i    = '0;
        mem_wdata_i   = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;

        // Readback, masked to field widths
        for (int s = 1; s <= int'(NUM_SOURCES); s++) begin
            bus_cycle(1'b1, prio_ofs(s), $urandom);
            bus_cycle(1'b0, prio_ofs(s), '0);
        end
        for (int t = 0; t < int'(NUM_TARGETS); t++) begin
            bus_cycle(1'b1, enable_ofs(t), 32'hFFFF_FFFF);
            bus_cycle(1'b0, enable_ofs(t), '0);
            bus_cycle(1'b1, thr_ofs(t), $urandom);
            bus_cycle(1'b0, thr_ofs(t), '0);
            bus_cycle(1'b1, thr_ofs(t), '0);
        end
        // Pending ignores writes, the rest are holes
        bus_cycle(1'b1, plic_pkg::OFS_PENDING, 32'hFFFF_FFFF);
        bus_cycle(1'b0, plic_pkg::OFS_PENDING, '0);
        bus_cycle(1'b0, prio_ofs(0), '0);
        bus_cycle(1'b1, prio_ofs(32), 32'h7);
        bus_cycle(1'b0, enable_ofs(NUM_TARGETS), '0);
        bus_cycle(1'b0, thr_ofs(NUM_TARGETS), '0);
        bus_cycle(1'b0, 32'h0000_2004, '0);

        // Known priorities with 3 and 5 tied and source 2 off
        for (int s = 1; s <= int'(NUM_SOURCES); s++) begin
            bus_cycle(1'b1, prio_ofs(s), '0);
        end
        bus_cycle(1'b1, prio_ofs(3), 32'd5);
        bus_cycle(1'b1, prio_ofs(5), 32'd5);

        // Edges to pending and irq
        pulse_source(2);
        bus_cycle(1'b0, plic_pkg::OFS_PENDING, '0);
        pulse_source(3);
        wait_irq(0, 1'b1);
        bus_cycle(1'b0, plic_pkg::OFS_PENDING, '0);

        // Claim picks ID 3 on the tie, second claim gets 0
        pulse_source(5);
        bus_cycle(1'b0, thr_ofs(0) + 32'd4, '0);
        bus_cycle(1'b0, thr_ofs(0) + 32'd4, '0);
        bus_cycle(1'b0, plic_pkg::OFS_PENDING, '0);

        // Wrong completion, dropped edge, then release
        bus_cycle(1'b1, thr_ofs(0) + 32'd4, 32'd5);
        pulse_source(3);
        bus_cycle(1'b1, thr_ofs(0) + 32'd4, 32'd3);
        bus_cycle(1'b0, plic_pkg::OFS_PENDING, '0);
        bus_cycle(1'b0, thr_ofs(0) + 32'd4, '0);
        bus_cycle(1'b1, thr_ofs(0) + 32'd4, 32'd5);
        pulse_source(3);
        wait_irq(0, 1'b1);

        // Threshold equal to priority masks target 0 only
        bus_cycle(1'b1, thr_ofs(0), 32'd5);
        wait_irq(0, 1'b0);
        wait_irq(1, 1'b1);
        bus_cycle(1'b0, thr_ofs(1) + 32'd4, '0);
        bus_cycle(1'b1, thr_ofs(1) + 32'd4, 32'd3);

        // ---------------------------------------------------------------
        // Random mix
        // ---------------------------------------------------------------
        for (int unsigned i = 0; i < RANDOM_CYC; i++) begin
            @(negedge clk_i);
            r = $urandom;
            if (r[1:0] == 2'b00) begin
                pin = $urandom_range(0, NUM_SOURCES - 1);
                irq_sources_i[pin] = ~irq_sources_i[pin];
            end
            mem_req_i  = r[4];
            mem_we_i   = r[5];
            mem_addr_i = PLIC_BASE + random_ofs();
            // Small values make completions hit the held claim
            mem_wdata_i = r[6] ? $urandom_range(0, NUM_SOURCES) : $urandom;
        end
        @(negedge clk_i);
        mem_req_i = 1'b0;
        repeat (5) @(negedge clk_i);

        $display("Errors: model mismatches %0d, testbench %0d", model_errors, tb_errors);
        if (model_errors == 0 && tb_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
